// ==== hw/carPkg.sv ====
package carPkg;

    typedef enum logic [3:0] {
        idle, start, count, straight, nudgeLeft, nudgeRight,
        choose, turnLeft, turnRight, back, stop, fault
    } navState;

    // Left sensor in bit 2, right sensor in bit 0
    typedef enum logic [2:0] {
        offRoad     = 3'b000,
        rightSlight = 3'b001,
        onLine      = 3'b010,
        rightEdge   = 3'b011,
        leftSlight  = 3'b100,
        junction101 = 3'b101,
        leftEdge    = 3'b110,
        crossing    = 3'b111
    } roadCode;

    typedef logic [3:0] digitCode;

    localparam digitCode digP     = 4'd10;
    localparam digitCode digDash  = 4'd11;
    localparam digitCode digD     = 4'd12;
    localparam digitCode digL     = 4'd13;
    localparam digitCode digE     = 4'd14;
    localparam digitCode digBlank = 4'd15;

    localparam int countSteps   = 3;
    localparam int rightConfirm = 3;

    // Segment order is g f e d c b a, active low
    function automatic logic [6:0] segTable(digitCode code);
        case (code)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            digP:    return 7'b0001100;
            digDash: return 7'b0111111;
            digD:    return 7'b0100001;
            digL:    return 7'b1000111;
            digE:    return 7'b0000110;
            default: return 7'b1111111;
        endcase
    endfunction

endpackage

// ==== hw/digitScanner.sv ====
`timescale 1ns/1ps

module digitScanner import carPkg::*; #(
    parameter int scanTicks = 3
) (
    input  logic           clk,
    input  logic           rst,
    input  digitCode [3:0] digits,
    output logic [3:0]     digitSel,
    output logic [6:0]     segments
);

    localparam int dwellW = (scanTicks > 1) ? $clog2(scanTicks) : 1;

    logic [dwellW-1:0] dwellCnt;
    logic [1:0]        scanIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwellCnt <= '0;
            scanIdx  <= 2'd0;
        end else if (dwellCnt == dwellW'(scanTicks - 1)) begin
            dwellCnt <= '0;
            scanIdx  <= scanIdx + 2'd1;
        end else begin
            dwellCnt <= dwellCnt + 1'b1;
        end
    end

    // One select low at a time
    assign digitSel = ~(4'b0001 << scanIdx);
    assign segments = segTable(digits[scanIdx]);

endmodule

// ==== hw/lineCar.sv ====
`timescale 1ns/1ps

module lineCar import carPkg::*; #(
    parameter int countTicks = 100_000_000,
    parameter int stopTicks  = 50_000_000,
    parameter int flashTicks = 25_000_000,
    parameter int lampTicks  = 30_000_000,
    parameter int scanTicks  = 100_000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        leftTrack,
    input  logic        midTrack,
    input  logic        rightTrack,
    output logic [15:0] led,
    output logic [3:0]  digitSel,
    output logic [6:0]  segments
);

    roadCode        road;
    logic           countRun;
    logic           stopRun;
    logic           backRun;
    logic [1:0]     countStep;
    logic           countDone;
    logic           countFlash;
    logic           stopDone;
    logic           backFlash;
    digitCode [3:0] digits;

    navIf navBus ();

    assign navBus.countStep  = countStep;
    assign navBus.countFlash = countFlash;
    assign navBus.backFlash  = backFlash;

    trackSampler trackSampler_i (
        .clk(clk), .rst(rst), .leftTrack(leftTrack), .midTrack(midTrack),
        .rightTrack(rightTrack), .road(road)
    );

    phaseTimer #(.stepTicks(countTicks), .steps(countSteps)) countTimer_i (
        .clk(clk), .rst(rst), .run(countRun), .step(countStep), .done(countDone),
        .flash(countFlash)
    );

    phaseTimer #(.stepTicks(stopTicks), .steps(1)) stopTimer_i (
        .clk(clk), .rst(rst), .run(stopRun), .step(), .done(stopDone), .flash()
    );

    phaseTimer #(.stepTicks(flashTicks), .steps(1)) backTimer_i (
        .clk(clk), .rst(rst), .run(backRun), .step(), .done(), .flash(backFlash)
    );

    navigator navigator_i (
        .clk(clk), .rst(rst), .enable(enable), .road(road), .countDone(countDone),
        .stopDone(stopDone), .countRun(countRun), .stopRun(stopRun), .backRun(backRun),
        .nav(navBus.nav)
    );

    statusPanel #(.lampTicks(lampTicks)) statusPanel_i (
        .clk(clk), .rst(rst), .road(road), .pan(navBus.panel), .led(led), .digits(digits)
    );

    digitScanner #(.scanTicks(scanTicks)) digitScanner_i (
        .clk(clk), .rst(rst), .digits(digits), .digitSel(digitSel), .segments(segments)
    );

endmodule

// ==== hw/navIf.sv ====
`timescale 1ns/1ps

interface navIf import carPkg::*; ();

    navState    state;
    logic       passed;
    // Timer side, fed at the top level
    logic [1:0] countStep;
    logic       countFlash;
    logic       backFlash;

    modport nav (
        output state,
        output passed
    );

    modport panel (
        input state,
        input passed,
        input countStep,
        input countFlash,
        input backFlash
    );

endinterface

// ==== hw/navigator.sv ====
`timescale 1ns/1ps

module navigator import carPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    enable,
    input  roadCode road,
    input  logic    countDone,
    input  logic    stopDone,
    output logic    countRun,
    output logic    stopRun,
    output logic    backRun,
    navIf.nav       nav
);

    navState    state;
    navState    nextState;
    navState    target;
    navState    newTarget;
    logic       setTarget;
    logic       passed;
    logic [1:0] confirmCnt;
    logic       confirmed;
    logic       curFamily;
    logic       nextFamily;

    assign confirmed  = (confirmCnt == 2'(rightConfirm));
    assign curFamily  = state inside {straight, nudgeLeft, nudgeRight};
    assign nextFamily = nextState inside {straight, nudgeLeft, nudgeRight};

    always_comb begin
        nextState = state;
        newTarget = target;
        setTarget = 1'b0;
        if (!enable) begin
            nextState = idle;
        end else begin
            case (state)
                idle: nextState = start;
                start: if (road == onLine) nextState = count;
                count: if (countDone) nextState = straight;
                straight, nudgeLeft, nudgeRight: begin
                    case (road)
                        offRoad: begin
                            nextState = stop;
                            newTarget = back;
                            setTarget = 1'b1;
                        end
                        crossing:    nextState = passed ? choose : straight;
                        rightSlight: nextState = nudgeRight;
                        leftSlight:  nextState = nudgeLeft;
                        default:     nextState = straight;
                    endcase
                end
                choose: begin
                    if (road == junction101) begin
                        nextState = stop;
                        newTarget = turnLeft;
                        setTarget = 1'b1;
                    end else if (road == crossing && passed) begin
                        nextState = straight;
                    end
                end
                turnLeft: begin
                    if (road == junction101) begin
                        nextState = stop;
                        newTarget = turnRight;
                        setTarget = 1'b1;
                    end else if (road == crossing && passed) begin
                        nextState = stop;
                        newTarget = straight;
                        setTarget = 1'b1;
                    end
                end
                turnRight: begin
                    if (road == junction101 && confirmed) begin
                        nextState = fault;
                    end else if (road == crossing && passed && confirmed) begin
                        nextState = stop;
                        newTarget = straight;
                        setTarget = 1'b1;
                    end
                end
                // No turn record, so back always resumes left
                back: begin
                    if (road == crossing) begin
                        nextState = stop;
                        newTarget = turnLeft;
                        setTarget = 1'b1;
                    end
                end
                stop: if (stopDone) nextState = target;
                default: nextState = state;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            target     <= idle;
            passed     <= 1'b0;
            confirmCnt <= 2'd0;
        end else begin
            state <= nextState;
            if (setTarget) begin
                target <= newTarget;
            end
            // Marker flag, so a state cannot leave on its entry marker
            if (state == count && nextState == straight) begin
                passed <= 1'b1;
            end else if (nextState != state && !(curFamily && nextFamily)) begin
                passed <= 1'b0;
            end else if (road != crossing) begin
                passed <= 1'b1;
            end
            if (state != turnRight) begin
                confirmCnt <= 2'd0;
            end else if (road == crossing && !confirmed) begin
                confirmCnt <= confirmCnt + 2'd1;
            end
        end
    end

    assign countRun   = (state == count);
    assign stopRun    = (state == stop);
    assign backRun    = (state == back);
    assign nav.state  = state;
    assign nav.passed = passed;

    stopHasTarget: assert property (
        @(posedge clk) disable iff (rst)
        (state == stop && $past(state) != stop) |-> $past(setTarget)
    );

    faultFromRight: assert property (
        @(posedge clk) disable iff (rst)
        (state == fault && $past(state) != fault) |-> $past(state) == turnRight
    );

endmodule

// ==== hw/phaseTimer.sv ====
`timescale 1ns/1ps

module phaseTimer #(
    parameter int stepTicks = 4,
    parameter int steps     = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    output logic [1:0] step,
    output logic       done,
    output logic       flash
);

    localparam int tickW = (stepTicks > 1) ? $clog2(stepTicks) : 1;

    logic [tickW-1:0] tickCnt;
    logic             tickWrap;

    assign tickWrap = (tickCnt == tickW'(stepTicks - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tickCnt <= '0;
            step    <= 2'd0;
            flash   <= 1'b0;
        end else if (!run) begin
            tickCnt <= '0;
            step    <= 2'd0;
            flash   <= 1'b0;
        end else if (tickWrap) begin
            tickCnt <= '0;
            flash   <= ~flash;
            // Step saturates, flash keeps going
            if (step != 2'(steps)) begin
                step <= step + 2'd1;
            end
        end else begin
            tickCnt <= tickCnt + 1'b1;
        end
    end

    assign done = (step == 2'(steps));

    // A finished phase only follows an enabled clock
    doneNeedsRun: assert property (
        @(posedge clk) disable iff (rst) $rose(done) |-> $past(run)
    );

endmodule

// ==== hw/statusPanel.sv ====
`timescale 1ns/1ps

module statusPanel import carPkg::*; #(
    parameter int lampTicks = 5
) (
    input  logic                clk,
    input  logic                rst,
    input  roadCode             road,
    navIf.panel                 pan,
    output logic [15:0]         led,
    output digitCode [3:0]      digits
);

    localparam int lampW = (lampTicks > 1) ? $clog2(lampTicks) : 1;

    logic [lampW-1:0] lampCnt;
    logic [2:0]       lamp;
    logic [4:0]       stateBits;
    logic [5:0]       activity;
    digitCode         passDigit;

    // Rotating lamp while waiting in choose
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (pan.state != choose) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (lampCnt == lampW'(lampTicks - 1)) begin
            lampCnt <= '0;
            lamp    <= {lamp[1:0], lamp[2]};
        end else begin
            lampCnt <= lampCnt + 1'b1;
        end
    end

    assign passDigit = pan.passed ? 4'd1 : 4'd0;

    always_comb begin
        case (pan.state)
            start:                           stateBits = 5'b00001;
            count:                           stateBits = 5'b00010;
            straight, nudgeLeft, nudgeRight: stateBits = 5'b01000;
            choose:                          stateBits = {lamp, 2'b00};
            turnLeft:                        stateBits = 5'b10000;
            turnRight:                       stateBits = 5'b00100;
            stop:                            stateBits = 5'b11100;
            back:                            stateBits = 5'b01010;
            fault:                           stateBits = 5'b11111;
            default:                         stateBits = 5'b00000;
        endcase
        case (pan.state)
            count:                           activity = pan.countFlash ? 6'b000000 : 6'b111111;
            straight, nudgeLeft, nudgeRight: activity = 6'b001100;
            turnRight:                       activity = 6'b000011;
            turnLeft:                        activity = 6'b110000;
            stop:                            activity = 6'b111111;
            back:                            activity = pan.backFlash ? 6'b000000 : 6'b111111;
            default:                         activity = 6'b000000;
        endcase
        // Digit 3 is leftmost
        case (pan.state)
            idle:  digits = {4'd1, digL, digD, digE};
            start: digits = {digDash, digDash, digDash, digDash};
            count: digits = {digDash, digDash, digDash, 4'(countSteps) - 4'(pan.countStep)};
            straight, nudgeLeft, nudgeRight: digits = {digP, 4'd2, digDash, passDigit};
            choose:    digits = {digP, 4'd1, digDash, passDigit};
            turnLeft:  digits = {digP, 4'd3, digDash, passDigit};
            turnRight: digits = {digP, 4'd4, digDash, passDigit};
            back, stop: digits = {4'd0, 4'd0, 4'd0, 4'd0};
            default:   digits = {digBlank, digBlank, digBlank, digBlank};
        endcase
    end

    assign led = {stateBits, 1'b0, activity, 1'b0, road};

endmodule

// ==== hw/trackSampler.sv ====
`timescale 1ns/1ps

module trackSampler import carPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    leftTrack,
    input  logic    midTrack,
    input  logic    rightTrack,
    output roadCode road
);

    logic [2:0] syncA;
    logic [2:0] syncB;

    // Sensors are asynchronous to clk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA <= 3'b000;
            syncB <= 3'b000;
        end else begin
            syncA <= {leftTrack, midTrack, rightTrack};
            syncB <= syncA;
        end
    end

    assign road = roadCode'(syncB);

endmodule

// ==== list.f ====
hw/carPkg.sv
hw/navIf.sv
hw/trackSampler.sv
hw/phaseTimer.sv
hw/navigator.sv
hw/statusPanel.sv
hw/digitScanner.sv
hw/lineCar.sv
sim/lineCarCheck.sv
sim/lineCarTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lineCarTb -f list.f -o simLineCar
./obj_dir/simLineCar | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== sim/lineCarCheck.sv ====
`timescale 1ns/1ps

module lineCarCheck import carPkg::*; #(
    parameter int countTicks = 8,
    parameter int stopTicks  = 6,
    parameter int flashTicks = 4,
    parameter int lampTicks  = 5,
    parameter int scanTicks  = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        leftTrack,
    input  logic        midTrack,
    input  logic        rightTrack,
    input  logic [15:0] led,
    input  logic [3:0]  digitSel,
    input  logic [6:0]  segments,
    output int          errors,
    output int          checks
);

    // Active-low segment patterns from g down to a
    localparam logic [6:0] segRef [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h0C, 7'h3F, 7'h21, 7'h47, 7'h06, 7'h7F
    };

    // Active-low select per scanned digit
    localparam logic [3:0] selRef [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

    logic [2:0]  trackA;
    roadCode     road;
    navState     state;
    navState     target;
    navState     nxt;
    logic        passed;
    logic        live;
    int          confirms;
    int          countClk;
    int          stopClk;
    int          backClk;
    int          lampClk;
    int          scanClk;
    int          scanIdx;
    logic [2:0]  lamp;
    logic [3:0]  expSel;
    logic [15:0] expLed;
    logic [15:0] expDigits;

    function automatic logic inFamily(navState st);
        return st inside {straight, nudgeLeft, nudgeRight};
    endfunction

    function automatic navState nextState(navState cur, roadCode rd, logic en, logic pass,
                                          logic conf, logic cDone, logic sDone, navState tgt);
        if (!en) return idle;
        case (cur)
            idle:      return start;
            start:     return (rd == onLine) ? count : start;
            count:     return cDone ? straight : count;
            choose: begin
                if (rd == junction101) return stop;
                return (rd == crossing && pass) ? straight : choose;
            end
            turnLeft:  return (rd == junction101 || (rd == crossing && pass)) ? stop : turnLeft;
            turnRight: begin
                if (rd == junction101 && conf) return fault;
                return (rd == crossing && pass && conf) ? stop : turnRight;
            end
            back:      return (rd == crossing) ? stop : back;
            stop:      return sDone ? tgt : stop;
            fault:     return fault;
            default: begin
                if (rd == offRoad) return stop;
                if (rd == crossing) return pass ? choose : straight;
                if (rd == rightSlight) return nudgeRight;
                return (rd == leftSlight) ? nudgeLeft : straight;
            end
        endcase
    endfunction

    // Resume state of the stop hold per entering state
    function automatic navState stopTarget(navState cur, roadCode rd);
        case (cur)
            choose, back: return turnLeft;
            turnLeft:     return (rd == junction101) ? turnRight : straight;
            turnRight:    return straight;
            default:      return back;
        endcase
    endfunction

    function automatic logic [15:0] ledWord(navState st, logic [2:0] lmp, logic cFlash,
                                            logic bFlash, roadCode rd);
        logic [4:0] top;
        logic [5:0] act;
        top = 5'b00000;
        act = 6'b000000;
        case (st)
            start:     top = 5'b00001;
            count:     top = 5'b00010;
            choose:    top = {lmp, 2'b00};
            turnLeft:  top = 5'b10000;
            turnRight: top = 5'b00100;
            stop:      top = 5'b11100;
            back:      top = 5'b01010;
            fault:     top = 5'b11111;
            default:   top = inFamily(st) ? 5'b01000 : 5'b00000;
        endcase
        case (st)
            count:     act = {6{!cFlash}};
            turnRight: act = 6'b000011;
            turnLeft:  act = 6'b110000;
            stop:      act = 6'b111111;
            back:      act = {6{!bFlash}};
            default:   act = inFamily(st) ? 6'b001100 : 6'b000000;
        endcase
        return {top, 1'b0, act, 1'b0, rd};
    endfunction

    // Digit 3 in the top nibble
    function automatic logic [15:0] digitsFor(navState st, logic pass, int step);
        case (st)
            idle:       return {4'd1, 4'd13, 4'd12, 4'd14};
            start:      return 16'hBBBB;
            count:      return {12'hBBB, 4'(countSteps - step)};
            choose:     return {4'hA, 4'd1, 4'hB, 3'b000, pass};
            turnLeft:   return {4'hA, 4'd3, 4'hB, 3'b000, pass};
            turnRight:  return {4'hA, 4'd4, 4'hB, 3'b000, pass};
            back, stop: return 16'h0000;
            fault:      return 16'hFFFF;
            default:    return {4'hA, 4'd2, 4'hB, 3'b000, pass};
        endcase
    endfunction

    assign nxt = nextState(state, road, enable, passed, confirms == rightConfirm,
                           countClk >= countSteps * countTicks, stopClk >= stopTicks, target);
    assign lamp      = 3'b001 << ((lampClk / lampTicks) % 3);
    assign scanIdx   = (scanClk / scanTicks) % 4;
    assign expSel    = selRef[scanIdx];
    assign expLed    = ledWord(state, lamp, ((countClk / countTicks) % 2) == 1,
                               ((backClk / flashTicks) % 2) == 1, road);
    assign expDigits = digitsFor(state, passed, countClk / countTicks);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            trackA   <= 3'b000;
            road     <= offRoad;
            state    <= idle;
            target   <= idle;
            passed   <= 1'b0;
            live     <= 1'b0;
            confirms <= 0;
            countClk <= 0;
            stopClk  <= 0;
            backClk  <= 0;
            lampClk  <= 0;
            scanClk  <= 0;
        end else begin
            live   <= 1'b1;
            trackA <= {leftTrack, midTrack, rightTrack};
            road   <= roadCode'(trackA);
            state  <= nxt;
            if (nxt == stop && state != stop) begin
                target <= stopTarget(state, road);
            end
            if (state == count && nxt == straight) begin
                passed <= 1'b1;
            end else if (nxt != state && !(inFamily(state) && inFamily(nxt))) begin
                passed <= 1'b0;
            end else if (road != crossing) begin
                passed <= 1'b1;
            end
            if (state != turnRight) begin
                confirms <= 0;
            end else if (road == crossing && confirms < rightConfirm) begin
                confirms <= confirms + 1;
            end
            countClk <= (state == count) ? countClk + 1 : 0;
            stopClk  <= (state == stop) ? stopClk + 1 : 0;
            backClk  <= (state == back) ? backClk + 1 : 0;
            lampClk  <= (state == choose) ? lampClk + 1 : 0;
            scanClk  <= scanClk + 1;
        end
    end

    initial begin
        errors = 0;
        checks = 0;
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (live) begin
            checks++;
            if (led !== expLed) begin
                errors++;
                $display("Error led: expected 0x%h, got 0x%h", expLed, led);
            end
            if (digitSel !== expSel) begin
                errors++;
                $display("Error digitSel: expected 0x%h, got 0x%h", expSel, digitSel);
            end
            if (segments !== segRef[expDigits[scanIdx*4 +: 4]]) begin
                errors++;
                $display("Error segments: expected 0x%h, got 0x%h",
                         segRef[expDigits[scanIdx*4 +: 4]], segments);
            end
        end
    end

endmodule

// ==== sim/lineCarTb.sv ====
`timescale 1ns/1ps

module lineCarTb import carPkg::*; ();

    localparam int countTicks = 8;
    localparam int stopTicks  = 6;
    localparam int flashTicks = 4;
    localparam int lampTicks  = 5;
    localparam int scanTicks  = 3;
    localparam int waitLimit  = 200;

    logic        clk;
    logic        rst;
    logic        enable;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    logic [3:0]  digitSel;
    logic [6:0]  segments;
    int          errors;
    int          checks;
    int          timeouts;

    lineCar #(
        .countTicks(countTicks), .stopTicks(stopTicks), .flashTicks(flashTicks),
        .lampTicks(lampTicks), .scanTicks(scanTicks)
    ) lineCar_i (
        .clk(clk), .rst(rst), .enable(enable), .leftTrack(leftTrack), .midTrack(midTrack),
        .rightTrack(rightTrack), .led(led), .digitSel(digitSel), .segments(segments)
    );

    lineCarCheck #(
        .countTicks(countTicks), .stopTicks(stopTicks), .flashTicks(flashTicks),
        .lampTicks(lampTicks), .scanTicks(scanTicks)
    ) check_i (
        .clk(clk), .rst(rst), .enable(enable), .leftTrack(leftTrack), .midTrack(midTrack),
        .rightTrack(rightTrack), .led(led), .digitSel(digitSel), .segments(segments),
        .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic setRoad(logic [2:0] code);
        {leftTrack, midTrack, rightTrack} = code;
    endtask

    // Hold the inputs for lo to lo+span-1 falling edges
    task automatic dwell(int lo, int span);
        int n;
        n = lo + ($urandom % span);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic waitState(logic [11:0] bits, logic [11:0] mask, string name);
        int n;
        n = 0;
        while (timeouts == 0 && (led[15:4] & mask) != bits) begin
            @(negedge clk);
            n++;
            if (n == waitLimit) begin
                $display("Timed out after %0d cycles waiting for state %s", n, name);
                timeouts++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha9f6_668e));
        timeouts = 0;
        rst      = 1'b1;
        enable   = 1'b0;
        setRoad(offRoad);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // Road code on the low LEDs while idle
        for (int i = 0; i < 6; i++) begin
            setRoad(3'($urandom % 8));
            dwell(2, 4);
        end
        setRoad(offRoad);
        enable = 1'b1;
        waitState(12'b00001_0000000, 12'hF80, "start");
        setRoad(onLine);
        waitState(12'b01000_0000000, 12'hF80, "straight");
        setRoad(leftSlight);
        dwell(2, 4);
        setRoad(rightSlight);
        dwell(2, 4);
        setRoad(onLine);
        dwell(2, 3);
        setRoad(crossing);
        waitState(12'b00100_0000000, 12'hFFF, "choose");
        dwell(12, 8);
        setRoad(junction101);
        waitState(12'b11100_0000000, 12'hF80, "stop");
        setRoad(onLine);
        waitState(12'b10000_0000000, 12'hF80, "turnLeft");
        setRoad(junction101);
        waitState(12'b11100_0000000, 12'hF80, "stop");
        setRoad(crossing);
        waitState(12'b00100_0000011, 12'hFFF, "turnRight");
        dwell(4, 3);
        setRoad(junction101);
        waitState(12'b11111_0000000, 12'hF80, "fault");
        dwell(2, 3);
        enable = 1'b0;
        waitState(12'b00000_0000000, 12'hF80, "idle");
        // Second route through back
        setRoad(onLine);
        enable = 1'b1;
        waitState(12'b01000_0000000, 12'hF80, "straight");
        setRoad(offRoad);
        waitState(12'b01010_0000000, 12'hF80, "back");
        dwell(16, 6);
        setRoad(crossing);
        waitState(12'b11100_0000000, 12'hF80, "stop");
        waitState(12'b10000_0000000, 12'hF80, "turnLeft");
        dwell(2, 3);
        enable = 1'b0;
        waitState(12'b00000_0000000, 12'hF80, "idle");
        setRoad(onLine);
        enable = 1'b1;
        waitState(12'b00010_0000000, 12'hF80, "count");
        dwell(3, 4);
        enable = 1'b0;
        waitState(12'b00000_0000000, 12'hF80, "idle");
        dwell(5, 1);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
